// ==== cachePkg.sv ====
package cachePkg;

	typedef logic [31:0]  addrT;    // byte address
	typedef logic [31:0]  wordT;
	typedef logic [3:0]   strbT;    // one bit per byte lane
	typedef logic [23:0]  tagT;     // addr 31..8
	typedef logic [2:0]   setIdxT;  // addr 7..5
	typedef logic [2:0]   wordOffT; // addr 4..2
	typedef logic [255:0] lineT;    // word 0 in bits 31..0
	typedef logic [3:0]   wayMaskT; // one-hot
	typedef logic [2:0]   plruT;    // root in bit 2, leaves below

	typedef struct packed {
		logic write;  // set for a store
		addrT addr;
		wordT wdata;
		strbT strb;
	} cpuReqT;

	typedef struct packed {
		logic valid;
		logic dirty;
		tagT  tag;
	} wayMetaT;

	typedef enum logic [3:0] {
		Idle,
		TagRead,
		WriteHit,
		ReadHit,
		Respond,
		Evict,
		WbReq,    // write-back request
		WbData,   // write-back burst
		FillReq,
		FillData,
		Refill
	} ctrlStateT;

	// one-hot select of a line out of the four ways
	function automatic lineT pickLine(wayMaskT sel, lineT [3:0] lines);
		lineT acc;
		acc = '0;
		for (int w = 0; w < 4; w++)
			if (sel[w])
				acc = acc | lines[w];
		return acc;
	endfunction

endpackage

// ==== cacheWay.sv ====
`timescale 1ns/1ps

module cacheWay (
	input  logic              clk,
	input  logic              rst,
	input  cachePkg::setIdxT  setIdx,
	input  logic              wrEn,
	input  cachePkg::wayMetaT wrMeta,
	input  cachePkg::lineT    wrLine,
	output cachePkg::wayMetaT rdMeta,
	output cachePkg::lineT    rdLine
);

	logic [7:0]     validQ;       // one flag per set
	logic [7:0]     dirtyQ;
	cachePkg::tagT  tagMem [8];
	cachePkg::lineT lineMem [8];

	// flags come up clear so every way starts invalid
	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= '0;
			dirtyQ <= '0;
		end else if (wrEn) begin
			validQ[setIdx] <= wrMeta.valid;
			dirtyQ[setIdx] <= wrMeta.dirty;
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (wrEn) begin
			tagMem[setIdx]  <= wrMeta.tag;
			lineMem[setIdx] <= wrLine;
		end
	end

	// async read of the addressed set
	assign rdMeta.valid = validQ[setIdx];
	assign rdMeta.dirty = dirtyQ[setIdx];
	assign rdMeta.tag   = tagMem[setIdx];
	assign rdLine       = lineMem[setIdx];

endmodule

// ==== victimSelect.sv ====
`timescale 1ns/1ps

module victimSelect (
	input  logic              clk,
	input  logic              rst,
	input  cachePkg::setIdxT  setIdx,
	input  cachePkg::wayMaskT validVec,
	input  cachePkg::wayMaskT hitWay,
	input  logic              touch,
	output cachePkg::wayMaskT victimWay
);

	// root set means ways 2/3 were used last
	// bit 1 set means way 1 used last, bit 0 set means way 3 used last
	cachePkg::plruT    plru [8];
	cachePkg::plruT    cur;
	cachePkg::wayMaskT lruWay;
	cachePkg::wayMaskT freeWay;
	logic              upperHit;
	logic              lowerHit;

	assign cur      = plru[setIdx];
	assign upperHit = hitWay[2] | hitWay[3];
	assign lowerHit = hitWay[0] | hitWay[1];

	// tree update one edge after a hit state
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < 8; s++)
				plru[s] <= '0;
		end else if (touch) begin
			plru[setIdx][2] <= upperHit;     // point root at the other half
			if (lowerHit)
				plru[setIdx][1] <= hitWay[1];
			if (upperHit)
				plru[setIdx][0] <= hitWay[3];
		end
	end

	// follow the tree to the least recent way
	always_comb begin
		if (cur[2])
			lruWay = cur[1] ? 4'b0001 : 4'b0010;
		else
			lruWay = cur[0] ? 4'b0100 : 4'b1000;
	end

	// lowest invalid way, scanned downward so way 0 wins
	always_comb begin
		freeWay = '0;
		for (int w = 3; w >= 0; w--)
			if (!validVec[w])
				freeWay = cachePkg::wayMaskT'(1 << w);
	end

	assign victimWay = (|freeWay) ? freeWay : lruWay;  // empty ways fill first

endmodule

// ==== lineMerge.sv ====
`timescale 1ns/1ps

module lineMerge (
	input  cachePkg::wayMaskT    hitWay,
	input  cachePkg::lineT [3:0] wayLines,
	input  cachePkg::cpuReqT     req,
	input  cachePkg::lineT       refillLine,
	input  logic                 useRefill,
	output cachePkg::wordT       rspData,
	output cachePkg::lineT       wrLine
);

	cachePkg::lineT    hitLine;
	cachePkg::wordOffT off;
	cachePkg::wordT    oldWord;
	cachePkg::wordT    newWord;
	cachePkg::lineT    mergedLine;

	assign off     = req.addr[4:2];                      // word within line
	assign hitLine = cachePkg::pickLine(hitWay, wayLines);
	assign oldWord = hitLine[{off, 5'b0} +: 32];

	// read data straight from the hit line
	assign rspData = oldWord;

	// byte lanes from the store where strobed
	always_comb begin
		for (int b = 0; b < 4; b++)
			newWord[b*8 +: 8] = req.strb[b] ? req.wdata[b*8 +: 8] : oldWord[b*8 +: 8];
	end

	// splice the merged word back in
	always_comb begin
		mergedLine = hitLine;
		mergedLine[{off, 5'b0} +: 32] = newWord;
	end

	// refill writes the fetched line untouched
	assign wrLine = useRefill ? refillLine : mergedLine;

endmodule

// ==== memPort.sv ====
`timescale 1ns/1ps

module memPort (
	input  logic                 clk,
	input  logic                 loadWb,
	input  cachePkg::lineT [3:0] wayLines,
	input  cachePkg::wayMaskT    victimWay,
	input  logic                 wrDataReady,
	input  logic                 wrActive,
	input  logic                 rdRspValid,
	input  cachePkg::wordT       rdRspData,
	input  logic                 rdActive,
	output cachePkg::wordT       wrData,
	output logic                 wrLast,
	output cachePkg::lineT       refillLine
);

	cachePkg::lineT    victimLine;
	cachePkg::lineT    wbShift;   // outgoing words, word 0 at bottom
	cachePkg::wordOffT beatCnt;   // write beats already sent
	logic              wrBeat;
	logic              rdBeat;

	assign victimLine = cachePkg::pickLine(victimWay, wayLines);

	assign wrBeat = wrActive & wrDataReady;  // accepted write-back beat
	assign rdBeat = rdActive & rdRspValid;   // accepted refill beat

	// write-back shifter and beat count
	always_ff @(posedge clk) begin
		if (loadWb) begin
			wbShift <= victimLine;
			beatCnt <= '0;
		end else if (wrBeat) begin
			wbShift <= wbShift >> 32;
			beatCnt <= beatCnt + 3'd1;
		end
	end

	assign wrData = wbShift[31:0];
	assign wrLast = wrActive & (beatCnt == 3'd7);  // eighth beat

	// refill words enter at the top and walk down
	// after eight beats word 0 sits in the low bits
	always_ff @(posedge clk) begin
		if (rdBeat)
			refillLine <= {rdRspData, refillLine[255:32]};
	end

endmodule

// ==== cacheCtrl.sv ====
`timescale 1ns/1ps

module cacheCtrl (
	input  logic                    clk,
	input  logic                    rst,
	input  cachePkg::cpuReqT        cpuReq,
	input  logic                    cpuReqValid,
	input  logic                    rspReady,
	input  logic                    memRdReqReady,
	input  logic                    memRdRspValid,
	input  logic                    memRdRspLast,
	input  logic                    memWrReqReady,
	input  logic                    memWrDataReady,
	input  logic                    wrLast,
	input  cachePkg::wayMetaT [3:0] wayMetas,
	input  cachePkg::wayMaskT       victimWay,
	output logic                    cpuReqReady,
	output logic                    rspValid,
	output logic                    memRdReqValid,
	output cachePkg::addrT          memRdReqAddr,
	output logic                    memRdRspReady,
	output logic                    memWrReqValid,
	output cachePkg::addrT          memWrReqAddr,
	output logic                    memWrDataValid,
	output cachePkg::cpuReqT        req,
	output cachePkg::wayMaskT       hitWay,
	output cachePkg::wayMaskT       wayWrEn,
	output cachePkg::wayMetaT       wrMeta,
	output logic                    touch,
	output logic                    loadWb,
	output logic                    useRefill,
	output logic                    wrActive,
	output logic                    rdActive
);

	cachePkg::ctrlStateT state;
	cachePkg::ctrlStateT nextState;
	cachePkg::tagT       reqTag;
	cachePkg::setIdxT    reqSet;
	cachePkg::wayMetaT   victimMeta;
	logic                hit;
	logic                victimDirty;

	assign reqTag = req.addr[31:8];
	assign reqSet = req.addr[7:5];

	// request captured on acceptance, held through the miss
	always_ff @(posedge clk) begin
		if (state == cachePkg::Idle && cpuReqValid)
			req <= cpuReq;
	end

	// tag compare in every way
	always_comb begin
		for (int w = 0; w < 4; w++)
			hitWay[w] = wayMetas[w].valid && (wayMetas[w].tag == reqTag);
	end
	assign hit = |hitWay;

	always_comb begin
		victimMeta = '0;
		for (int w = 0; w < 4; w++)
			if (victimWay[w])
				victimMeta = victimMeta | wayMetas[w];
	end
	assign victimDirty = victimMeta.valid & victimMeta.dirty;

	always_ff @(posedge clk) begin
		if (rst)
			state <= cachePkg::Idle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;  // hold by default while ready is low
		case (state)
			cachePkg::Idle:     if (cpuReqValid) nextState = cachePkg::TagRead;
			cachePkg::TagRead: begin
				if (!hit)
					nextState = cachePkg::Evict;
				else
					nextState = req.write ? cachePkg::WriteHit : cachePkg::ReadHit;
			end
			cachePkg::WriteHit: nextState = cachePkg::Idle;
			cachePkg::ReadHit:  nextState = cachePkg::Respond;
			cachePkg::Respond:  if (rspReady) nextState = cachePkg::Idle;
			cachePkg::Evict:    nextState = victimDirty ? cachePkg::WbReq : cachePkg::FillReq;
			cachePkg::WbReq:    if (memWrReqReady) nextState = cachePkg::WbData;
			cachePkg::WbData:   if (memWrDataReady && wrLast) nextState = cachePkg::FillReq;
			cachePkg::FillReq:  if (memRdReqReady) nextState = cachePkg::FillData;
			cachePkg::FillData: if (memRdRspValid && memRdRspLast) nextState = cachePkg::Refill;
			cachePkg::Refill:   nextState = req.write ? cachePkg::WriteHit : cachePkg::ReadHit;
			default:            nextState = cachePkg::Idle;
		endcase
	end

	// handshake outputs decoded from state
	assign cpuReqReady    = (state == cachePkg::Idle);
	assign rspValid       = (state == cachePkg::Respond);
	assign memWrReqValid  = (state == cachePkg::WbReq);
	assign memWrDataValid = (state == cachePkg::WbData);
	assign memRdReqValid  = (state == cachePkg::FillReq);
	assign memRdRspReady  = (state == cachePkg::FillData);

	assign memWrReqAddr = {victimMeta.tag, reqSet, 5'b0};  // line-aligned victim
	assign memRdReqAddr = {reqTag, reqSet, 5'b0};

	// datapath steering
	assign touch     = (state == cachePkg::ReadHit) || (state == cachePkg::WriteHit);
	assign loadWb    = (state == cachePkg::WbReq);
	assign wrActive  = (state == cachePkg::WbData);
	assign rdActive  = (state == cachePkg::FillData);
	assign useRefill = (state == cachePkg::Refill);

	// store hits the hit way, refill lands in the victim
	always_comb begin
		case (state)
			cachePkg::WriteHit: wayWrEn = hitWay;
			cachePkg::Refill:   wayWrEn = victimWay;
			default:            wayWrEn = '0;
		endcase
	end

	assign wrMeta.valid = 1'b1;
	assign wrMeta.dirty = (state == cachePkg::WriteHit);  // refill writes clean
	assign wrMeta.tag   = reqTag;

endmodule

// ==== dcacheTop.sv ====
`timescale 1ns/1ps

module dcacheTop (
	input  logic             clk,
	input  logic             rst,
	input  cachePkg::cpuReqT cpuReq,
	input  logic             cpuReqValid,
	output logic             cpuReqReady,
	output logic             rspValid,
	output cachePkg::wordT   rspData,
	input  logic             rspReady,
	output logic             memRdReqValid,
	output cachePkg::addrT   memRdReqAddr,
	input  logic             memRdReqReady,
	input  logic             memRdRspValid,
	input  cachePkg::wordT   memRdRspData,
	input  logic             memRdRspLast,
	output logic             memRdRspReady,
	output logic             memWrReqValid,
	output cachePkg::addrT   memWrReqAddr,
	input  logic             memWrReqReady,
	output logic             memWrDataValid,
	output cachePkg::wordT   memWrData,
	output logic             memWrDataLast,
	input  logic             memWrDataReady
);

	cachePkg::cpuReqT        req;         // registered request
	cachePkg::wayMaskT       hitWay;
	cachePkg::wayMaskT       victimWay;
	cachePkg::wayMaskT       wayWrEn;
	cachePkg::wayMetaT       wrMeta;
	cachePkg::wayMetaT [3:0] wayMetas;
	cachePkg::lineT [3:0]    wayLines;
	cachePkg::lineT          wrLine;
	cachePkg::lineT          refillLine;
	logic                    touch;
	logic                    loadWb;
	logic                    useRefill;
	logic                    wrActive;
	logic                    rdActive;

	cacheCtrl uCtrl (
		.clk, .rst, .cpuReq, .cpuReqValid, .rspReady,
		.memRdReqReady, .memRdRspValid, .memRdRspLast,
		.memWrReqReady, .memWrDataReady,
		.wrLast(memWrDataLast), .wayMetas, .victimWay,
		.cpuReqReady, .rspValid, .memRdReqValid, .memRdReqAddr, .memRdRspReady,
		.memWrReqValid, .memWrReqAddr, .memWrDataValid,
		.req, .hitWay, .wayWrEn, .wrMeta, .touch, .loadWb, .useRefill, .wrActive, .rdActive
	);

	// four identical ways indexed by the request set
	for (genvar w = 0; w < 4; w++) begin : gWay
		cacheWay uWay (
			.clk, .rst, .setIdx(req.addr[7:5]), .wrEn(wayWrEn[w]),
			.wrMeta, .wrLine, .rdMeta(wayMetas[w]), .rdLine(wayLines[w])
		);
	end

	victimSelect uVictim (
		.clk, .rst, .setIdx(req.addr[7:5]),
		.validVec({wayMetas[3].valid, wayMetas[2].valid, wayMetas[1].valid, wayMetas[0].valid}),
		.hitWay, .touch, .victimWay
	);

	lineMerge uMerge (
		.hitWay, .wayLines, .req, .refillLine, .useRefill, .rspData, .wrLine
	);

	memPort uMem (
		.clk, .loadWb, .wayLines, .victimWay,
		.wrDataReady(memWrDataReady), .wrActive,
		.rdRspValid(memRdRspValid), .rdRspData(memRdRspData), .rdActive,
		.wrData(memWrData), .wrLast(memWrDataLast), .refillLine
	);

endmodule

// ==== dcacheAssert.sv ====
`timescale 1ns/1ps

module dcacheAssert (
	input logic              clk,
	input logic              rst,
	input logic              cpuReqReady,
	input logic              rspValid,
	input logic              rspReady,
	input cachePkg::wordT    rspData,
	input logic              memRdReqValid,
	input logic              memRdReqReady,
	input cachePkg::addrT    memRdReqAddr,
	input logic              memWrReqValid,
	input logic              memWrReqReady,
	input cachePkg::addrT    memWrReqAddr,
	input logic              memWrDataValid,
	input logic              memWrDataReady,
	input cachePkg::wordT    memWrData,
	input cachePkg::wayMaskT wayWrEn
);

	// valids hold with a steady payload until taken
	rdReqHold: assert property (@(posedge clk) disable iff (rst)
		memRdReqValid && !memRdReqReady |=> memRdReqValid && $stable(memRdReqAddr))
		else $error("memRdReqValid dropped or address moved before acceptance");
	wrReqHold: assert property (@(posedge clk) disable iff (rst)
		memWrReqValid && !memWrReqReady |=> memWrReqValid && $stable(memWrReqAddr))
		else $error("memWrReqValid dropped or address moved before acceptance");
	wrDataHold: assert property (@(posedge clk) disable iff (rst)
		memWrDataValid && !memWrDataReady |=> memWrDataValid && $stable(memWrData))
		else $error("memWrDataValid dropped or data moved before acceptance");
	rspHold: assert property (@(posedge clk) disable iff (rst)
		rspValid && !rspReady |=> rspValid && $stable(rspData))
		else $error("rspValid dropped or data moved before acceptance");

	// at most one way written per edge
	wayWrOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(wayWrEn))
		else $error("wayWrEn has more than one bit set");

	// a taken response hands the port straight back to the CPU
	rspThenReady: assert property (@(posedge clk) disable iff (rst)
		rspValid && rspReady |=> cpuReqReady && !rspValid)
		else $error("cpuReqReady not back alone in the cycle after a response");

endmodule

bind dcacheTop dcacheAssert uAssert (
	.clk, .rst, .cpuReqReady, .rspValid, .rspReady, .rspData,
	.memRdReqValid, .memRdReqReady, .memRdReqAddr,
	.memWrReqValid, .memWrReqReady, .memWrReqAddr,
	.memWrDataValid, .memWrDataReady, .memWrData, .wayWrEn
);

// ==== tbDcache.sv ====
`timescale 1ns/1ps

module tbDcache;

	localparam int MemWords   = 1024;                 // 4 KB backing store
	localparam int NumRandom  = 400;
	localparam int MaxReqs    = NumRandom + 128 + 16; // random, readback, directed
	localparam int CycleLimit = 200 * MaxReqs + 20;

	logic                clk = 1'b0;
	logic                rst;
	cachePkg::cpuReqT    cpuReq;
	logic                cpuReqValid;
	logic                cpuReqReady;
	logic                rspValid;
	cachePkg::wordT      rspData;
	logic                rspReady;
	logic                memRdReqValid;
	cachePkg::addrT      memRdReqAddr;
	logic                memRdReqReady;
	logic                memRdRspValid;
	cachePkg::wordT      memRdRspData;
	logic                memRdRspLast;
	logic                memRdRspReady;
	logic                memWrReqValid;
	cachePkg::addrT      memWrReqAddr;
	logic                memWrReqReady;
	logic                memWrDataValid;
	cachePkg::wordT      memWrData;
	logic                memWrDataLast;
	logic                memWrDataReady;

	cachePkg::wordT      mem [MemWords];     // memory model contents
	cachePkg::wordT      shadow [MemWords];  // what the CPU should see
	cachePkg::wordT      expQ [$];           // expected read data in issue order
	cachePkg::addrT      lastRdAddr;
	cachePkg::addrT      lastWbAddr;
	logic [31:0]         rngState;
	logic [127:0]        touched;            // words hit by random traffic
	logic                backPressure;
	logic                runDone = 1'b0;
	logic                timedOut = 1'b0;
	string               curTest;
	int cycleCnt = 0;
	int rspCount = 0;
	int rspCycle = 0;
	int rspChecks = 0;
	int rspErrs = 0;
	int memErrs = 0;
	int mainErrs = 0;
	int mainChecks = 0;
	int wbCount = 0;
	int acceptCycle;
	int errSnap;
	int chkSnap;
	int testsRun = 0;

	dcacheTop i_dut (.*);

	initial forever #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// initial memory image that mixes every address bit
	function automatic cachePkg::wordT fillPattern(input cachePkg::addrT a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	// reference model applies byte-strobed stores to the shadow and returns its word
	function automatic cachePkg::wordT refModel(input cachePkg::cpuReqT r);
		int             idx;
		cachePkg::wordT w;
		idx = int'(r.addr[11:2]);
		w = shadow[idx];
		if (r.write) begin
			for (int b = 0; b < 4; b++)
				if (r.strb[b])
					w[b*8 +: 8] = r.wdata[b*8 +: 8];
			shadow[idx] = w;
		end
		return w;
	endfunction

	// drives one CPU request and returns once the cache is done with it
	task automatic cpuAccess(input logic wr, input cachePkg::addrT a,
			input cachePkg::wordT d, input cachePkg::strbT s);
		cachePkg::cpuReqT r;
		int               want;
		r.write = wr;
		r.addr  = a;
		r.wdata = d;
		r.strb  = s;
		want = rspCount + 1;
		if (!wr)
			expQ.push_back(refModel(r));
		else
			void'(refModel(r));
		cpuReq = r;
		cpuReqValid = 1'b1;
		@(posedge clk);
		while (!cpuReqReady)
			@(posedge clk);
		acceptCycle = cycleCnt;
		#1;
		cpuReqValid = 1'b0;
		if (wr) begin
			@(posedge clk);
			while (!cpuReqReady)
				@(posedge clk);  // back in Idle
			#1;
		end else begin
			while (rspCount < want) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		errSnap = rspErrs + memErrs + mainErrs;
		chkSnap = rspChecks + mainChecks;
	endtask

	task automatic endTest();
		int errs;
		errs = rspErrs + memErrs + mainErrs - errSnap;
		$display("test %-15s %s, %0d checks, %0d errors", curTest, (errs == 0) ? "ok" : "bad",
			rspChecks + mainChecks - chkSnap, errs);
		testsRun++;
	endtask

	// memory model whose ready and valid roll only under back-pressure
	initial begin : memModel
		logic [31:0] r;
		logic [31:0] bpState;
		logic        rdBusy;
		logic        wrBusy;
		logic        rdTaken;
		int          rdBase;
		int          wrBase;
		int          rdBeat;
		int          wrBeat;
		bpState = 32'hb368;
		rdBusy = 1'b0;
		wrBusy = 1'b0;
		rdBase = 0;
		wrBase = 0;
		rdBeat = 0;
		wrBeat = 0;
		memRdReqReady = 1'b0;
		memRdRspValid = 1'b0;
		memRdRspData = '0;
		memRdRspLast = 1'b0;
		memWrReqReady = 1'b0;
		memWrDataReady = 1'b0;
		rspReady = 1'b0;
		for (int i = 0; i < MemWords; i++)
			mem[i] = fillPattern(i * 4);
		forever begin
			@(posedge clk);
			rdTaken = memRdRspValid && memRdRspReady;
			if (memRdReqValid && memRdReqReady) begin
				lastRdAddr = memRdReqAddr;
				if (memRdReqAddr[4:0] != 5'd0) begin
					$display("read request address %h is not line-aligned", memRdReqAddr);
					memErrs++;
				end
				rdBase = int'(memRdReqAddr[11:5]) * 8;
				rdBeat = 0;
				rdBusy = 1'b1;
			end
			if (rdTaken) begin
				rdBeat++;
				if (rdBeat == 8)
					rdBusy = 1'b0;
			end
			if (memWrReqValid && memWrReqReady) begin
				lastWbAddr = memWrReqAddr;
				if (memWrReqAddr[4:0] != 5'd0) begin
					$display("write-back address %h is not line-aligned", memWrReqAddr);
					memErrs++;
				end
				wrBase = int'(memWrReqAddr[11:5]) * 8;
				wrBeat = 0;
				wrBusy = 1'b1;
			end
			if (memWrDataValid && memWrDataReady) begin
				if (!wrBusy) begin
					$display("write-back data beat arrived without an accepted request");
					memErrs++;
				end else begin
					if (memWrDataLast !== (wrBeat == 7)) begin
						$display("write-back last flag wrong on beat %0d", wrBeat);
						memErrs++;
					end
					mem[wrBase + wrBeat] = memWrData;  // word 0 first
					wrBeat++;
					if (wrBeat == 8) begin
						wrBusy = 1'b0;
						wbCount++;
					end
				end
			end
			#1;
			r = xorshift(bpState);
			bpState = r;
			memRdReqReady = !rdBusy && (!backPressure || r[1:0] != 2'b00);
			memWrDataReady = wrBusy && (!backPressure || r[3:2] != 2'b00);
			rspReady = !backPressure || r[5:4] != 2'b00;
			memWrReqReady = !wrBusy && (!backPressure || r[7:6] != 2'b00);
			if (rdBusy && (!memRdRspValid || rdTaken)) begin
				memRdRspValid = !backPressure || r[9:8] != 2'b00;
				memRdRspData = mem[rdBase + rdBeat];
				memRdRspLast = (rdBeat == 7);
			end else if (!rdBusy) begin
				memRdRspValid = 1'b0;  // burst over
			end
		end
	end

	// response checker
	always @(posedge clk) begin : compare
		cachePkg::wordT want;
		if (!rst && rspValid && rspReady) begin
			if (expQ.size() == 0) begin
				$display("response arrived with no read outstanding");
				rspErrs++;
			end else begin
				want = expQ.pop_front();
				if (rspData !== want) begin
					$display("FAIL %s expected %h actual %h", curTest, want, rspData);
					rspErrs++;
				end
				rspChecks++;
			end
			rspCount++;
			rspCycle = cycleCnt;
		end
	end

	always @(negedge clk) begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt > CycleLimit) begin
			timedOut = 1'b1;
			$display("timeout, run stopped after %0d cycles without finishing", cycleCnt);
			$display("Test failed");
			$finish;
		end
	end

	initial begin : mainSeq
		cachePkg::addrT a;
		cachePkg::wordT d;
		logic [31:0]    r;
		logic [3:0]     sel;
		logic [6:0]     t;
		int             wbBefore;
		int             base;
		int             total;
		rst = 1'b1;
		cpuReq = '0;
		cpuReqValid = 1'b0;
		backPressure = 1'b0;
		rngState = 32'hb368;
		touched = '0;
		for (int i = 0; i < MemWords; i++)
			shadow[i] = fillPattern(i * 4);
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		startTest("refill_read");
		cpuAccess(1'b0, 32'h0000_0104, '0, '0);  // tag 1 set 0 cold miss
		if (lastRdAddr !== 32'h0000_0100) begin
			$display("FAIL %s expected %h actual %h", curTest, 32'h0000_0100, lastRdAddr);
			mainErrs++;
		end
		mainChecks++;
		endTest();

		startTest("strobe_merge");
		cpuAccess(1'b1, 32'h0000_0328, 32'hdead_beef, 4'b0101);
		cpuAccess(1'b1, 32'h0000_0328, 32'h1234_5678, 4'b1000);
		cpuAccess(1'b0, 32'h0000_0328, '0, '0);
		endTest();

		startTest("hit_latency");
		cpuAccess(1'b0, 32'h0000_0260, '0, '0);  // brings the line in
		cpuAccess(1'b0, 32'h0000_026c, '0, '0);
		if (rspCycle - acceptCycle != 3) begin
			$display("FAIL %s expected %0d actual %0d", curTest, 3, rspCycle - acceptCycle);
			mainErrs++;
		end
		mainChecks++;
		endTest();

		// five dirty lines into set 2 so the fifth evicts one
		startTest("dirty_evict");
		wbBefore = wbCount;
		for (int k = 0; k < 5; k++) begin
			r = xorshift(rngState);
			rngState = r;
			a = {8'h00, 16'(k), 3'd2, 3'(k), 2'b00};
			cpuAccess(1'b1, a, r, 4'hf);
		end
		if (wbCount - wbBefore != 1) begin
			$display("FAIL %s expected %0d actual %0d", curTest, 1, wbCount - wbBefore);
			mainErrs++;
		end
		if (lastWbAddr[4:0] != 5'd0 || lastWbAddr[7:5] != 3'd2) begin
			$display("write-back address %h is not a line of set 2", lastWbAddr);
			mainErrs++;
		end
		base = int'(lastWbAddr[11:5]) * 8;
		for (int w = 0; w < 8; w++) begin
			if (mem[base + w] !== shadow[base + w]) begin
				$display("FAIL %s expected %h actual %h", curTest, shadow[base + w],
					mem[base + w]);
				mainErrs++;
			end
			mainChecks++;
		end
		endTest();

		// tags 8..11 over sets 0,2,4,6
		startTest("random_traffic");
		backPressure = 1'b1;
		for (int i = 0; i < NumRandom; i++) begin
			r = xorshift(rngState);
			d = xorshift(r);
			rngState = d;
			sel = r[3:0];
			a = {20'h0, 2'b10, sel, 1'b0, r[6:4], 2'b00};
			touched[{sel, r[6:4]}] = 1'b1;
			cpuAccess(r[7], a, d, r[11:8]);
		end
		for (int i = 0; i < 128; i++) begin
			if (touched[i]) begin
				t = 7'(i);
				a = {20'h0, 2'b10, t[6:3], 1'b0, t[2:0], 2'b00};
				cpuAccess(1'b0, a, '0, '0);
			end
		end
		endTest();

		total = rspErrs + memErrs + mainErrs;
		$display("summary %0d tests, %0d checks, %0d errors", testsRun,
			rspChecks + mainChecks, total);
		runDone = 1'b1;
		if (total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// run stopped some other way such as an assertion
	final begin
		if (!runDone && !timedOut)
			$display("Test failed");
	end

endmodule

// ==== all.f ====
cachePkg.sv
cacheWay.sv
victimSelect.sv
lineMerge.sv
memPort.sv
cacheCtrl.sv
dcacheTop.sv
dcacheAssert.sv
tbDcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tbDcache -o simDcache
if [ $? -ne 0 ]; then
	echo "verilator build error"
	exit 1
fi

./obj_dir/simDcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" sim.log; then
	exit 0
fi
exit 1
